// ==== common/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// datapath and address width
`define LSU_XLEN 32

// scratchpad size in words
`define LSU_RAM_WORDS 64

// request queue entries
`define LSU_QUEUE_DEPTH 2

// return path register stages
`define LSU_LOAD_PIPE_REGS 1
`define LSU_STORE_PIPE_REGS 1

// scoreboard tag width
`define LSU_TRANS_ID_BITS 3

`endif

// ==== common/lsu_pkg.sv ====
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    // load and store opcodes, bit 3 set for stores
    typedef enum logic [3:0] {
        LB  = 4'h0,
        LBU = 4'h1,
        LH  = 4'h2,
        LHU = 4'h3,
        LW  = 4'h4,
        SB  = 4'h8,
        SH  = 4'h9,
        SW  = 4'ha
    } lsu_op_e;

    typedef enum logic [1:0] {
        NO_EXC             = 2'd0,
        LD_ADDR_MISALIGNED = 2'd1,
        ST_ADDR_MISALIGNED = 2'd2
    } exc_cause_e;

    // one queued request, wdata already in its byte lanes
    typedef struct packed {
        lsu_op_e                       op;
        logic [`LSU_XLEN-1:0]          vaddr;
        logic [`LSU_XLEN-1:0]          wdata;
        logic [`LSU_XLEN/8-1:0]        be;
        logic                          misaligned;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } lsu_req_t;

    function automatic logic is_store(input lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

// ==== common/lsu_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// head of the request queue, shared by the load and store units
interface lsu_req_if;
    import lsu_pkg::*;

    logic     valid;
    lsu_req_t req;
    logic     ld_pop;
    logic     st_pop;

    modport queue (
        output valid, req,
        input  ld_pop, st_pop
    );

    modport unit (
        input  valid, req,
        output ld_pop, st_pop
    );

endinterface

`default_nettype wire

// ==== logic/lsu_agu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_agu (
    input  lsu_pkg::lsu_op_e               op_i,
    input  logic [`LSU_XLEN-1:0]           operand_a_i,
    input  logic [`LSU_XLEN-1:0]           imm_i,
    input  logic [`LSU_XLEN-1:0]           store_data_i,
    input  logic [`LSU_TRANS_ID_BITS-1:0]  trans_id_i,
    output lsu_pkg::lsu_req_t              req_o
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0]   vaddr;
    logic [`LSU_XLEN/8-1:0] be;
    logic                   misaligned;

    // base plus signed offset, bare mode so this is the physical address
    assign vaddr = $unsigned($signed(operand_a_i) + $signed(imm_i));

    // --------------------------------------------------
    // byte enables and misalignment
    // --------------------------------------------------
    always_comb begin
        be         = '0;
        misaligned = 1'b0;
        unique case (op_i)
            LB, LBU, SB: begin
                be = (`LSU_XLEN/8)'(4'b0001) << vaddr[1:0];
            end
            LH, LHU, SH: begin
                be         = (`LSU_XLEN/8)'(4'b0011) << vaddr[1:0];
                misaligned = vaddr[0];
            end
            default: begin
                // word access
                be         = '1;
                misaligned = (vaddr[1:0] != 2'b00);
            end
        endcase
    end

    always_comb begin
        req_o            = '0;
        req_o.op         = op_i;
        req_o.vaddr      = vaddr;
        // move store data into the addressed lanes
        req_o.wdata      = store_data_i << {vaddr[1:0], 3'b000};
        req_o.be         = be;
        req_o.misaligned = misaligned;
        req_o.trans_id   = trans_id_i;
    end

endmodule

`default_nettype wire

// ==== logic/lsu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_data_ram (
    input  logic                                clk_i,
    input  logic                                wr_en_i,
    input  logic [$clog2(`LSU_RAM_WORDS)-1:0]   wr_addr_i,
    input  logic [`LSU_XLEN/8-1:0]              wr_be_i,
    input  logic [`LSU_XLEN-1:0]                wr_data_i,
    input  logic                                rd_en_i,
    input  logic [$clog2(`LSU_RAM_WORDS)-1:0]   rd_addr_i,
    output logic [`LSU_XLEN-1:0]                rd_data_o
);

    logic [`LSU_XLEN-1:0] mem_q [`LSU_RAM_WORDS];

    // per-byte write
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (wr_be_i[b]) begin
                    mem_q[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // registered read, holds its value when idle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_load_unit (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    lsu_req_if.unit                             head,
    output logic                                rd_en_o,
    output logic [$clog2(`LSU_RAM_WORDS)-1:0]   rd_addr_o,
    input  logic [`LSU_XLEN-1:0]                rd_data_i,
    output logic                                valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0]       trans_id_o,
    output logic [`LSU_XLEN-1:0]                result_o,
    output lsu_pkg::exc_cause_e                 exc_o
);
    import lsu_pkg::*;

    localparam int unsigned AW = $clog2(`LSU_RAM_WORDS);

    logic                          s1_valid_q;
    lsu_op_e                       s1_op_q;
    logic [`LSU_XLEN-1:0]          s1_vaddr_q;
    logic                          s1_mis_q;
    logic [`LSU_TRANS_ID_BITS-1:0] s1_id_q;

    logic                          s2_valid_q;
    lsu_op_e                       s2_op_q;
    logic [`LSU_XLEN-1:0]          s2_vaddr_q;
    logic                          s2_mis_q;
    logic [`LSU_TRANS_ID_BITS-1:0] s2_id_q;

    logic [`LSU_XLEN-1:0]          lane_data;

    assign head.ld_pop = head.valid & ~is_store(head.req.op);

    // --------------------------------------------------
    // address stage, issues the read
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= head.ld_pop;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (head.ld_pop) begin
            s1_op_q    <= head.req.op;
            s1_vaddr_q <= head.req.vaddr;
            s1_mis_q   <= head.req.misaligned;
            s1_id_q    <= head.req.trans_id;
        end
        s2_op_q    <= s1_op_q;
        s2_vaddr_q <= s1_vaddr_q;
        s2_mis_q   <= s1_mis_q;
        s2_id_q    <= s1_id_q;
    end

    // faulting loads never touch the scratchpad
    assign rd_en_o   = s1_valid_q & ~s1_mis_q;
    assign rd_addr_o = s1_vaddr_q[AW+1:2];

    // --------------------------------------------------
    // data stage, lane select and extension
    // --------------------------------------------------
    assign lane_data = rd_data_i >> {s2_vaddr_q[1:0], 3'b000};

    always_comb begin
        unique case (s2_op_q)
            LB:      result_o = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            LBU:     result_o = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
            LH:      result_o = {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            LHU:     result_o = {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
            default: result_o = rd_data_i;
        endcase
        // report the faulting address in place of data
        if (s2_mis_q) begin
            result_o = s2_vaddr_q;
        end
    end

    assign valid_o    = s2_valid_q;
    assign trans_id_o = s2_id_q;
    assign exc_o      = s2_mis_q ? LD_ADDR_MISALIGNED : NO_EXC;

endmodule

`default_nettype wire

// ==== logic/lsu_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_queue (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              valid_i,
    output logic              ready_o,
    lsu_req_if.queue          head
);
    import lsu_pkg::*;

    localparam int unsigned DEPTH = `LSU_QUEUE_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    lsu_req_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;
    logic             empty;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count_q == '0);
    assign ready_o = (count_q < CNT_W'(DEPTH));
    assign push    = valid_i & ready_o;
    assign pop     = head.ld_pop | head.st_pop;

    // bypass when empty
    assign head.valid = ~empty | push;
    assign head.req   = empty ? req_i : mem_q[rd_ptr_q];

    // every accepted request is written, a bypassed pop just skips over it
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_store_unit (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    lsu_req_if.unit                             head,
    output logic                                wr_en_o,
    output logic [$clog2(`LSU_RAM_WORDS)-1:0]   wr_addr_o,
    output logic [`LSU_XLEN/8-1:0]              wr_be_o,
    output logic [`LSU_XLEN-1:0]                wr_data_o,
    output logic                                valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0]       trans_id_o,
    output lsu_pkg::exc_cause_e                 exc_o
);
    import lsu_pkg::*;

    localparam int unsigned AW = $clog2(`LSU_RAM_WORDS);

    logic                          s1_valid_q;
    logic [AW-1:0]                 s1_addr_q;
    logic [`LSU_XLEN/8-1:0]        s1_be_q;
    logic [`LSU_XLEN-1:0]          s1_wdata_q;
    logic                          s1_mis_q;
    logic [`LSU_TRANS_ID_BITS-1:0] s1_id_q;

    assign head.st_pop = head.valid & is_store(head.req.op);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= head.st_pop;
        end
    end

    // address stage
    always_ff @(posedge clk_i) begin
        if (head.st_pop) begin
            s1_addr_q  <= head.req.vaddr[AW+1:2];
            s1_be_q    <= head.req.be;
            s1_wdata_q <= head.req.wdata;
            s1_mis_q   <= head.req.misaligned;
            s1_id_q    <= head.req.trans_id;
        end
    end

    // write happens at the edge that closes the address stage
    assign wr_en_o    = s1_valid_q & ~s1_mis_q;
    assign wr_addr_o  = s1_addr_q;
    assign wr_be_o    = s1_be_q;
    assign wr_data_o  = s1_wdata_q;

    assign valid_o    = s1_valid_q;
    assign trans_id_o = s1_id_q;
    assign exc_o      = s1_mis_q ? ST_ADDR_MISALIGNED : NO_EXC;

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           lsu_valid_i,
    output logic                           lsu_ready_o,
    input  lsu_pkg::lsu_op_e               op_i,
    input  logic [`LSU_XLEN-1:0]           operand_a_i,
    input  logic [`LSU_XLEN-1:0]           imm_i,
    input  logic [`LSU_XLEN-1:0]           store_data_i,
    input  logic [`LSU_TRANS_ID_BITS-1:0]  trans_id_i,
    output logic                           load_valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0]  load_trans_id_o,
    output logic [`LSU_XLEN-1:0]           load_result_o,
    output lsu_pkg::exc_cause_e            load_exception_o,
    output logic                           store_valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0]  store_trans_id_o,
    output lsu_pkg::exc_cause_e            store_exception_o
);
    import lsu_pkg::*;

    localparam int unsigned AW      = $clog2(`LSU_RAM_WORDS);
    localparam int unsigned LD_REGS = `LSU_LOAD_PIPE_REGS;
    localparam int unsigned ST_REGS = `LSU_STORE_PIPE_REGS;

    lsu_req_t                      agu_req;
    logic                          ld_valid;
    logic [`LSU_TRANS_ID_BITS-1:0] ld_trans_id;
    logic [`LSU_XLEN-1:0]          ld_result;
    exc_cause_e                    ld_exc;
    logic                          st_valid;
    logic [`LSU_TRANS_ID_BITS-1:0] st_trans_id;
    exc_cause_e                    st_exc;
    logic                          rd_en;
    logic [AW-1:0]                 rd_addr;
    logic [`LSU_XLEN-1:0]          rd_data;
    logic                          wr_en;
    logic [AW-1:0]                 wr_addr;
    logic [`LSU_XLEN/8-1:0]        wr_be;
    logic [`LSU_XLEN-1:0]          wr_data;

    lsu_req_if req_bus ();

    lsu_agu i_agu (
        .op_i         ( op_i         ),
        .operand_a_i  ( operand_a_i  ),
        .imm_i        ( imm_i        ),
        .store_data_i ( store_data_i ),
        .trans_id_i   ( trans_id_i   ),
        .req_o        ( agu_req      )
    );

    lsu_queue i_queue (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .req_i   ( agu_req       ),
        .valid_i ( lsu_valid_i   ),
        .ready_o ( lsu_ready_o   ),
        .head    ( req_bus.queue )
    );

    lsu_load_unit i_load_unit (
        .clk_i      ( clk_i        ),
        .rst_ni     ( rst_ni       ),
        .head       ( req_bus.unit ),
        .rd_en_o    ( rd_en        ),
        .rd_addr_o  ( rd_addr      ),
        .rd_data_i  ( rd_data      ),
        .valid_o    ( ld_valid     ),
        .trans_id_o ( ld_trans_id  ),
        .result_o   ( ld_result    ),
        .exc_o      ( ld_exc       )
    );

    lsu_store_unit i_store_unit (
        .clk_i      ( clk_i        ),
        .rst_ni     ( rst_ni       ),
        .head       ( req_bus.unit ),
        .wr_en_o    ( wr_en        ),
        .wr_addr_o  ( wr_addr      ),
        .wr_be_o    ( wr_be        ),
        .wr_data_o  ( wr_data      ),
        .valid_o    ( st_valid     ),
        .trans_id_o ( st_trans_id  ),
        .exc_o      ( st_exc       )
    );

    lsu_data_ram i_data_ram (
        .clk_i     ( clk_i   ),
        .wr_en_i   ( wr_en   ),
        .wr_addr_i ( wr_addr ),
        .wr_be_i   ( wr_be   ),
        .wr_data_i ( wr_data ),
        .rd_en_i   ( rd_en   ),
        .rd_addr_i ( rd_addr ),
        .rd_data_o ( rd_data )
    );

    // --------------------------------------------------
    // return path pipeline registers
    // --------------------------------------------------
    logic                          ld_pipe_valid_q [LD_REGS];
    logic [`LSU_TRANS_ID_BITS-1:0] ld_pipe_id_q    [LD_REGS];
    logic [`LSU_XLEN-1:0]          ld_pipe_res_q   [LD_REGS];
    exc_cause_e                    ld_pipe_exc_q   [LD_REGS];
    logic                          st_pipe_valid_q [ST_REGS];
    logic [`LSU_TRANS_ID_BITS-1:0] st_pipe_id_q    [ST_REGS];
    exc_cause_e                    st_pipe_exc_q   [ST_REGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < LD_REGS; i++) begin
                ld_pipe_valid_q[i] <= 1'b0;
            end
            for (int i = 0; i < ST_REGS; i++) begin
                st_pipe_valid_q[i] <= 1'b0;
            end
        end else begin
            ld_pipe_valid_q[0] <= ld_valid;
            st_pipe_valid_q[0] <= st_valid;
            for (int i = 1; i < LD_REGS; i++) begin
                ld_pipe_valid_q[i] <= ld_pipe_valid_q[i-1];
            end
            for (int i = 1; i < ST_REGS; i++) begin
                st_pipe_valid_q[i] <= st_pipe_valid_q[i-1];
            end
        end
    end

    // payload follows its valid bit
    always_ff @(posedge clk_i) begin
        ld_pipe_id_q[0]  <= ld_trans_id;
        ld_pipe_res_q[0] <= ld_result;
        ld_pipe_exc_q[0] <= ld_exc;
        st_pipe_id_q[0]  <= st_trans_id;
        st_pipe_exc_q[0] <= st_exc;
        for (int i = 1; i < LD_REGS; i++) begin
            ld_pipe_id_q[i]  <= ld_pipe_id_q[i-1];
            ld_pipe_res_q[i] <= ld_pipe_res_q[i-1];
            ld_pipe_exc_q[i] <= ld_pipe_exc_q[i-1];
        end
        for (int i = 1; i < ST_REGS; i++) begin
            st_pipe_id_q[i]  <= st_pipe_id_q[i-1];
            st_pipe_exc_q[i] <= st_pipe_exc_q[i-1];
        end
    end

    assign load_valid_o      = ld_pipe_valid_q[LD_REGS-1];
    assign load_trans_id_o   = ld_pipe_id_q[LD_REGS-1];
    assign load_result_o     = ld_pipe_res_q[LD_REGS-1];
    assign load_exception_o  = ld_pipe_exc_q[LD_REGS-1];
    assign store_valid_o     = st_pipe_valid_q[ST_REGS-1];
    assign store_trans_id_o  = st_pipe_id_q[ST_REGS-1];
    assign store_exception_o = st_pipe_exc_q[ST_REGS-1];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f tb.f -o lsu_sim

out=$(./obj_dir/lsu_sim) || true
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "^Simulation PASSED$"

// ==== tb.f ====
+incdir+common
common/lsu_pkg.sv
common/lsu_req_if.sv
logic/lsu_agu.sv
logic/lsu_queue.sv
logic/lsu_load_unit.sv
logic/lsu_store_unit.sv
logic/lsu_data_ram.sv
logic/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

// ==== test/lsu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_assert (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           lsu_valid_i,
    input  logic                           lsu_ready_o,
    input  lsu_pkg::lsu_op_e               op_i,
    input  logic [`LSU_XLEN-1:0]           operand_a_i,
    input  logic [`LSU_XLEN-1:0]           imm_i,
    input  logic [`LSU_XLEN-1:0]           store_data_i,
    input  logic [`LSU_TRANS_ID_BITS-1:0]  trans_id_i,
    input  logic                           load_valid_o,
    input  logic [`LSU_TRANS_ID_BITS-1:0]  load_trans_id_o,
    input  logic [`LSU_XLEN-1:0]           load_result_o,
    input  lsu_pkg::exc_cause_e            load_exception_o,
    input  logic                           store_valid_o,
    input  logic [`LSU_TRANS_ID_BITS-1:0]  store_trans_id_o,
    input  lsu_pkg::exc_cause_e            store_exception_o
);
    import lsu_pkg::*;

    localparam int unsigned AW = $clog2(`LSU_RAM_WORDS);
    localparam int unsigned FD = 16;

    // shadow of the scratchpad as of the last accepted store
    logic [`LSU_XLEN-1:0]          shadow [`LSU_RAM_WORDS];
    logic [`LSU_TRANS_ID_BITS-1:0] ld_id_q  [FD];
    logic [`LSU_XLEN-1:0]          ld_res_q [FD];
    exc_cause_e                    ld_exc_q [FD];
    logic [`LSU_TRANS_ID_BITS-1:0] st_id_q  [FD];
    exc_cause_e                    st_exc_q [FD];
    logic [3:0]                    ld_wr;
    logic [3:0]                    ld_rd;
    logic [3:0]                    st_wr;
    logic [3:0]                    st_rd;
    int                            in_flight;
    int unsigned                   fail_cnt = 0;

    logic [`LSU_XLEN-1:0] addr;
    logic [AW-1:0]        idx;
    logic                 accept;
    logic                 st_op;
    logic                 mis;
    int                   off;
    int                   size;
    logic                 ld_ok;
    logic                 st_ok;

    function automatic logic [31:0] expected_load(input lsu_op_e op, input logic [31:0] word,
                                                  input logic [1:0] lane);
        logic [31:0] lanes;
        lanes = word >> (8 * int'(lane));
        case (op)
            LB:      return {{24{lanes[7]}}, lanes[7:0]};
            LBU:     return {24'h0, lanes[7:0]};
            LH:      return {{16{lanes[15]}}, lanes[15:0]};
            LHU:     return {16'h0, lanes[15:0]};
            default: return word;
        endcase
    endfunction

    assign addr   = operand_a_i + imm_i;
    assign idx    = addr[AW+1:2];
    assign accept = lsu_valid_i & lsu_ready_o;
    assign st_op  = op_i inside {SB, SH, SW};
    assign off    = int'(addr[1:0]);

    always_comb begin
        size = 4;
        mis  = (addr[1:0] != 2'b00);
        if (op_i inside {LB, LBU, SB}) begin
            size = 1;
            mis  = 1'b0;
        end else if (op_i inside {LH, LHU, SH}) begin
            size = 2;
            mis  = addr[0];
        end
    end

    // --------------------------------------------------
    // expected results per kind in acceptance order
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ld_wr     <= '0;
            ld_rd     <= '0;
            st_wr     <= '0;
            st_rd     <= '0;
            in_flight <= 0;
        end else begin
            if (accept && st_op) begin
                st_wr <= st_wr + 4'd1;
            end
            if (accept && !st_op) begin
                ld_wr <= ld_wr + 4'd1;
            end
            if (load_valid_o) begin
                ld_rd <= ld_rd + 4'd1;
            end
            if (store_valid_o) begin
                st_rd <= st_rd + 4'd1;
            end
            in_flight <= in_flight + int'(accept) - int'(load_valid_o) - int'(store_valid_o);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && st_op) begin
            st_id_q[st_wr]  <= trans_id_i;
            st_exc_q[st_wr] <= mis ? ST_ADDR_MISALIGNED : NO_EXC;
            if (!mis) begin
                for (int b = 0; b < 4; b++) begin
                    if (b >= off && b < off + size) begin
                        shadow[idx][8*b +: 8] <= store_data_i[8*(b-off) +: 8];
                    end
                end
            end
        end
        if (accept && !st_op) begin
            ld_id_q[ld_wr]  <= trans_id_i;
            ld_exc_q[ld_wr] <= mis ? LD_ADDR_MISALIGNED : NO_EXC;
            ld_res_q[ld_wr] <= mis ? addr : expected_load(op_i, shadow[idx], addr[1:0]);
        end
    end

    assign ld_ok = (ld_rd != ld_wr) && (load_trans_id_o == ld_id_q[ld_rd]) &&
                   (load_result_o == ld_res_q[ld_rd]) && (load_exception_o == ld_exc_q[ld_rd]);
    assign st_ok = (st_rd != st_wr) && (store_trans_id_o == st_id_q[st_rd]) &&
                   (store_exception_o == st_exc_q[st_rd]);

    load_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_valid_o |-> ld_ok)
        else begin
            fail_cnt++;
            $error("load result, id or cause differs from the shadow model");
        end

    store_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
        store_valid_o |-> st_ok)
        else begin
            fail_cnt++;
            $error("store id or cause differs from the shadow model");
        end

    // nothing outstanding means quiet outputs and a ready queue
    idle_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (in_flight == 0) |-> (lsu_ready_o && !load_valid_o && !store_valid_o))
        else begin
            fail_cnt++;
            $error("activity or back-pressure with no request outstanding");
        end

    // one request leaves the queue every cycle so it never fills
    ready_never_drops: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ready_o)
        else begin
            fail_cnt++;
            $error("ready low although the queue drains one request per cycle");
        end

endmodule

bind lsu_top lsu_assert u_check (.*);

`default_nettype wire

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int unsigned TIMEOUT = 200;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          lsu_valid_i;
    logic                          lsu_ready_o;
    lsu_op_e                       op_i;
    logic [`LSU_XLEN-1:0]          operand_a_i;
    logic [`LSU_XLEN-1:0]          imm_i;
    logic [`LSU_XLEN-1:0]          store_data_i;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i;
    logic                          load_valid_o;
    logic [`LSU_TRANS_ID_BITS-1:0] load_trans_id_o;
    logic [`LSU_XLEN-1:0]          load_result_o;
    exc_cause_e                    load_exception_o;
    logic                          store_valid_o;
    logic [`LSU_TRANS_ID_BITS-1:0] store_trans_id_o;
    exc_cause_e                    store_exception_o;

    logic [31:0]                   rng;
    logic [`LSU_TRANS_ID_BITS-1:0] next_id;
    int unsigned                   accepted = 0;
    int unsigned                   returned = 0;
    int unsigned                   timeouts = 0;
    int unsigned                   timeouts_seen = 0;
    int unsigned                   assert_seen = 0;
    int unsigned                   passed_tests = 0;
    int unsigned                   failed_tests = 0;
    lsu_op_e                       ops [8] = '{LB, LBU, LH, LHU, LW, SB, SH, SW};

    lsu_top dut0 (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .lsu_valid_i       ( lsu_valid_i       ),
        .lsu_ready_o       ( lsu_ready_o       ),
        .op_i              ( op_i              ),
        .operand_a_i       ( operand_a_i       ),
        .imm_i             ( imm_i             ),
        .store_data_i      ( store_data_i      ),
        .trans_id_i        ( trans_id_i        ),
        .load_valid_o      ( load_valid_o      ),
        .load_trans_id_o   ( load_trans_id_o   ),
        .load_result_o     ( load_result_o     ),
        .load_exception_o  ( load_exception_o  ),
        .store_valid_o     ( store_valid_o     ),
        .store_trans_id_o  ( store_trans_id_o  ),
        .store_exception_o ( store_exception_o )
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // count handshakes and results at the edge
    always @(posedge clk_i) begin
        if (lsu_valid_i && lsu_ready_o) begin
            accepted <= accepted + 1;
        end
        returned <= returned + 32'(load_valid_o) + 32'(store_valid_o);
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send(input lsu_op_e op, input logic [31:0] base, input logic [31:0] offset,
                        input logic [31:0] data);
        int unsigned waited;
        waited       = 0;
        op_i         = op;
        operand_a_i  = base;
        imm_i        = offset;
        store_data_i = data;
        trans_id_i   = next_id;
        lsu_valid_i  = 1'b1;
        while (!lsu_ready_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!lsu_ready_o) begin
            $display("timeout: request was never accepted");
            timeouts++;
        end
        @(negedge clk_i);
        lsu_valid_i = 1'b0;
        next_id     = next_id + 1'b1;
    endtask

    task automatic drain();
        int unsigned waited;
        waited = 0;
        while (returned != accepted && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (returned != accepted) begin
            $display("timeout: results still missing after %0d cycles", waited);
            timeouts++;
        end
    endtask

    task automatic finish_test(input string name);
        int unsigned new_errors;
        drain();
        new_errors  = dut0.u_check.fail_cnt - assert_seen;
        assert_seen = dut0.u_check.fail_cnt;
        if (returned != accepted) begin
            $display("[FAIL] %s: result count expected %0d actual %0d", name, accepted, returned);
            failed_tests++;
        end else if (new_errors != 0) begin
            $display("test %s failed: %0d assertion checks did not hold", name, new_errors);
            failed_tests++;
        end else if (timeouts != timeouts_seen) begin
            $display("test %s failed: a request was not accepted in time", name);
            failed_tests++;
        end else begin
            $display("[PASS] %s", name);
            passed_tests++;
        end
        timeouts_seen = timeouts;
    endtask

    initial begin
        rst_ni       = 1'b0;
        lsu_valid_i  = 1'b0;
        op_i         = LW;
        operand_a_i  = '0;
        imm_i        = '0;
        store_data_i = '0;
        trans_id_i   = '0;
        next_id      = '0;
        rng          = 32'hc5c8ad07;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        repeat (5) @(negedge clk_i);
        finish_test("idle_after_reset");

        // --------------------------------------------------
        // words 0..7 get defined contents first
        // --------------------------------------------------
        for (int k = 0; k < 8; k++) begin
            rng = next_random(rng);
            send(SW, 32'h100 + 32'(k * 4) + 32'd20, -32'sd20, rng);
        end
        for (int k = 0; k < 8; k++) begin
            send(LW, 32'(k * 4) + 32'd8, -32'sd8, 32'h0);
        end
        finish_test("word_round_trip");

        for (int k = 0; k < 8; k++) begin
            rng = next_random(rng);
            send(SB, 32'(k * 4), 32'(rng[1:0]), rng);
            rng = next_random(rng);
            send(SH, 32'(k * 4), 32'({rng[3], 1'b0}), rng);
        end
        for (int k = 0; k < 8; k++) begin
            rng = next_random(rng);
            send(LB, 32'(k * 4), 32'(rng[1:0]), 32'h0);
            send(LBU, 32'(k * 4), 32'(rng[3:2]), 32'h0);
            send(LH, 32'(k * 4), 32'({rng[4], 1'b0}), 32'h0);
            send(LHU, 32'(k * 4), 32'({rng[5], 1'b0}), 32'h0);
            send(LW, 32'(k * 4), 32'h0, 32'h0);
        end
        finish_test("sub_word_access");

        send(LH, 32'h0, 32'd1, 32'h0);
        send(LHU, 32'h4, 32'd3, 32'h0);
        send(LW, 32'h8, 32'd2, 32'h0);
        send(LW, 32'hc, 32'd1, 32'h0);
        rng = next_random(rng);
        send(SH, 32'h10, 32'd1, rng);
        rng = next_random(rng);
        send(SW, 32'h14, 32'd3, rng);
        send(SW, 32'h18, 32'd2, ~rng);
        // memory behind the faulting stores is unchanged
        send(LW, 32'h10, 32'h0, 32'h0);
        send(LW, 32'h14, 32'h0, 32'h0);
        send(LW, 32'h18, 32'h0, 32'h0);
        finish_test("misaligned_requests");

        for (int n = 0; n < 40; n++) begin
            rng = next_random(rng);
            send(ops[rng[2:0]], 32'({rng[5:3], 2'b00}), 32'(rng[7:6]), next_random(rng));
        end
        finish_test("order_and_backpressure");

        $display("tests: %0d passed, %0d failed, %0d results", passed_tests, failed_tests,
                 returned);
        if (failed_tests == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
